//--- common/uart_pkg.sv
// Fixed 8N1 frame with Sample_clk at 8x the bit rate; other formats need edits to these constants
package uart_pkg;

  // Frame format
  localparam int unsigned WORD_SIZE       = 8;  // Data bits per frame
  localparam int unsigned HALF_WORD       = 4;  // Start edge to middle of start bit
  localparam int unsigned SAMPLES_PER_BIT = 8;  // Sample_clk cycles per bit

  // Widths that carry a meaning
  typedef logic [WORD_SIZE-1:0] rx_word_t;      // Received data byte
  typedef logic [3:0]           sample_cnt_t;   // Counts up to SAMPLES_PER_BIT
  typedef logic [4:0]           bit_cnt_t;      // Reaches WORD_SIZE

  // Receiver FSM states
  typedef enum logic [1:0] {
    idle      = 2'b00,
    starting  = 2'b01,  // Waiting for middle of start bit
    receiving = 2'b10   // Sampling data bits and stop bit
  } rcv_state_e;

  // Controller strobes to the datapath
  typedef struct packed {
    logic clr_sample;   // Clear sample counter
    logic inc_sample;   // Advance sample counter
    logic clr_bit;      // Clear bit counter
    logic inc_bit;      // Advance bit counter
    logic shift;        // Shift serial_in into the shift register
    logic load;         // Copy shift register into data register
  } rcv_ctrl_t;

  // Datapath state seen by the controller
  typedef struct packed {
    rcv_state_e  state;
    sample_cnt_t sample_count;
    bit_cnt_t    bit_count;
  } rcv_status_t;

  // Outcome of one frame, valid while done is high
  typedef struct packed {
    logic done;         // One-cycle end-of-frame pulse
    logic overrun;      // Previous word still unread
    logic framing;      // Stop bit sampled low
  } rx_event_t;

  // Flags visible to the host
  typedef struct packed {
    logic data_avail;   // Word waiting in rd_data
    logic overrun_seen; // Sticky until next completed read
    logic framing_seen; // Sticky until next completed read
  } host_status_t;

endpackage

//--- rcvr/rcvr_controller.sv
// Pure combinational receiver FSM; serial_in must already be synchronous to Sample_clk
`timescale 1ns/1ps

module rcvr_controller (
  input  uart_pkg::rcv_status_t rcv_status,
  input  logic                  serial_in,
  input  logic                  host_busy,   // Previous word not yet read
  output uart_pkg::rcv_state_e  next_state,
  output uart_pkg::rcv_ctrl_t   ctrl,
  output uart_pkg::rx_event_t   rx_event
);

  always_comb begin
    next_state = rcv_status.state;  // Hold state unless told otherwise
    ctrl       = '0;
    rx_event   = '0;

    case (rcv_status.state)
      uart_pkg::idle: begin
        if (!serial_in) begin
          next_state = uart_pkg::starting;  // Possible start edge
        end
      end

      uart_pkg::starting: begin
        if (serial_in) begin
          next_state      = uart_pkg::idle;  // False start, drop it
          ctrl.clr_sample = 1'b1;
        end else if (rcv_status.sample_count ==
                     uart_pkg::sample_cnt_t'(uart_pkg::HALF_WORD - 1)) begin
          next_state      = uart_pkg::receiving;  // Start bit confirmed at mid-bit
          ctrl.clr_sample = 1'b1;
        end else begin
          ctrl.inc_sample = 1'b1;
        end
      end

      uart_pkg::receiving: begin
        if (rcv_status.sample_count <
            uart_pkg::sample_cnt_t'(uart_pkg::SAMPLES_PER_BIT - 1)) begin
          ctrl.inc_sample = 1'b1;
        end else begin
          ctrl.clr_sample = 1'b1;  // Middle of a bit cell
          if (rcv_status.bit_count != uart_pkg::bit_cnt_t'(uart_pkg::WORD_SIZE)) begin
            ctrl.shift   = 1'b1;  // Next data bit
            ctrl.inc_bit = 1'b1;
          end else begin
            // Stop bit cell; frame ends here whatever the outcome
            next_state    = uart_pkg::idle;
            ctrl.clr_bit  = 1'b1;
            rx_event.done = 1'b1;
            if (host_busy) begin
              rx_event.overrun = 1'b1;  // Byte dropped, old word kept
            end else if (!serial_in) begin
              rx_event.framing = 1'b1;  // Missing stop bit
            end else begin
              ctrl.load = 1'b1;
            end
          end
        end
      end

      default: begin
        next_state = uart_pkg::idle;
      end
    endcase

    // Checked on the settled strobes of this same evaluation
    if (ctrl.load) begin
      assert (!rx_event.overrun && !rx_event.framing)
        else $error("rcvr_controller: load together with an error flag");
    end
    if (ctrl.shift) begin
      assert (rcv_status.state == uart_pkg::receiving)
        else $error("rcvr_controller: shift outside receiving");
    end
  end

endmodule

//--- rcvr/rcvr_datapath.sv
// Registers of the receiver; every strobe takes effect on the next Sample_clk edge
`timescale 1ns/1ps

module rcvr_datapath (
  input  logic                  Sample_clk,
  input  logic                  reset_,      // Synchronous, active low
  input  uart_pkg::rcv_state_e  next_state,
  input  uart_pkg::rcv_ctrl_t   ctrl,
  input  logic                  serial_in,
  output uart_pkg::rcv_status_t rcv_status,
  output uart_pkg::rx_word_t    data
);

  uart_pkg::rcv_state_e  state;
  uart_pkg::sample_cnt_t sample_count;
  uart_pkg::bit_cnt_t    bit_count;
  uart_pkg::rx_word_t    shift_reg;   // First received bit ends in bit 0

  always_ff @(posedge Sample_clk) begin
    if (!reset_) begin
      state        <= uart_pkg::idle;
      sample_count <= '0;
      bit_count    <= '0;
      shift_reg    <= '0;
      data         <= '0;
    end else begin
      state <= next_state;

      if (ctrl.clr_sample) begin  // Clear wins over increment
        sample_count <= '0;
      end else if (ctrl.inc_sample) begin
        sample_count <= sample_count + uart_pkg::sample_cnt_t'(1);
      end

      if (ctrl.clr_bit) begin
        bit_count <= '0;
      end else if (ctrl.inc_bit) begin
        bit_count <= bit_count + uart_pkg::bit_cnt_t'(1);
      end

      if (ctrl.shift) begin
        shift_reg <= {serial_in, shift_reg[uart_pkg::WORD_SIZE-1:1]};  // LSB first on the line
      end

      if (ctrl.load) begin
        data <= shift_reg;  // Only on a clean frame
      end
    end
  end

  assign rcv_status.state        = state;
  assign rcv_status.sample_count = sample_count;
  assign rcv_status.bit_count    = bit_count;

  // The controller must stop shifting once a full word is held
  a_bit_count_range : assert property (
    @(posedge Sample_clk) disable iff (!reset_)
      bit_count <= uart_pkg::bit_cnt_t'(uart_pkg::WORD_SIZE)
  ) else $error("rcvr_datapath: bit_count %0d beyond word size", bit_count);

endmodule

//--- rcvr/uart_rcvr.sv
// Partitioned 8N1 receiver; one frame outcome per done pulse, no buffering beyond one word
`timescale 1ns/1ps

module uart_rcvr (
  input  logic                Sample_clk,
  input  logic                reset_,
  input  logic                serial_in,
  input  logic                host_busy,  // High while an unread word waits
  output uart_pkg::rx_event_t rx_event,
  output uart_pkg::rx_word_t  data
);

  uart_pkg::rcv_ctrl_t   ctrl;
  uart_pkg::rcv_state_e  next_state;
  uart_pkg::rcv_status_t rcv_status;

  // Next-state and strobe logic
  rcvr_controller rcvr_controller_i (
    .rcv_status (rcv_status),
    .serial_in  (serial_in),
    .host_busy  (host_busy),
    .next_state (next_state),
    .ctrl       (ctrl),
    .rx_event   (rx_event)
  );

  // State, counters and data registers
  rcvr_datapath rcvr_datapath_i (
    .Sample_clk (Sample_clk),
    .reset_     (reset_),
    .next_state (next_state),
    .ctrl       (ctrl),
    .serial_in  (serial_in),
    .rcv_status (rcv_status),
    .data       (data)
  );

endmodule

//--- hdl/rx_host_port.sv
// Single-word host side; rd_data is only guaranteed valid while rd_ack is high
`timescale 1ns/1ps

module rx_host_port (
  input  logic                   Sample_clk,
  input  logic                   reset_,
  input  logic                   rd_req,
  input  uart_pkg::rx_event_t    rx_event,
  output logic                   rd_ack,
  output logic                   host_busy,
  output uart_pkg::host_status_t status
);

  typedef enum logic {
    hs_wait = 1'b0,  // Waiting for rd_req with a word present
    hs_ack  = 1'b1   // Acknowledging, waiting for rd_req to drop
  } hs_state_e;

  hs_state_e hs_state;
  logic      hs_done;   // Last phase of the handshake

  assign hs_done = (hs_state == hs_ack) && !rd_req;

  always_ff @(posedge Sample_clk) begin
    if (!reset_) begin
      hs_state <= hs_wait;
    end else begin
      case (hs_state)
        hs_wait: if (rd_req && status.data_avail) hs_state <= hs_ack;
        hs_ack:  if (!rd_req) hs_state <= hs_wait;
        default: hs_state <= hs_wait;
      endcase
    end
  end

  always_ff @(posedge Sample_clk) begin
    if (!reset_) begin
      status <= '0;
    end else begin
      if (hs_done) begin
        status <= '0;  // Read finished, word and errors consumed
      end
      // A new frame outcome wins over the clear on the same edge
      if (rx_event.done) begin
        if (rx_event.overrun) begin
          status.overrun_seen <= 1'b1;
        end else if (rx_event.framing) begin
          status.framing_seen <= 1'b1;
        end else begin
          status.data_avail <= 1'b1;
        end
      end
    end
  end

  assign rd_ack    = (hs_state == hs_ack);
  assign host_busy = status.data_avail;

  // rd_ack only rises after rd_req was seen
  a_ack_needs_req : assert property (
    @(posedge Sample_clk) disable iff (!reset_)
      rd_ack |-> ($past(rd_req) || $past(rd_ack))
  ) else $error("rx_host_port: rd_ack rose without rd_req");

  // rd_ack holds as long as the host keeps rd_req high
  a_ack_holds : assert property (
    @(posedge Sample_clk) disable iff (!reset_)
      (rd_ack && rd_req) |=> rd_ack
  ) else $error("rx_host_port: rd_ack fell while rd_req high");

endmodule

//--- hdl/uart_rx_top.sv
// Serial receive subsystem; serial_in must be synchronous to Sample_clk at 8x bit rate
`timescale 1ns/1ps

module uart_rx_top (
  input  logic                   Sample_clk,
  input  logic                   reset_,
  input  logic                   serial_in,
  input  logic                   rd_req,
  output logic                   rd_ack,
  output uart_pkg::rx_word_t     rd_data,   // Last good byte, held until the next one
  output uart_pkg::host_status_t status
);

  uart_pkg::rx_event_t rx_event;
  logic                host_busy;

  // Receiver, data goes straight out
  uart_rcvr uart_rcvr_i (
    .Sample_clk (Sample_clk),
    .reset_     (reset_),
    .serial_in  (serial_in),
    .host_busy  (host_busy),
    .rx_event   (rx_event),
    .data       (rd_data)
  );

  // Flags and read handshake
  rx_host_port rx_host_port_i (
    .Sample_clk (Sample_clk),
    .reset_     (reset_),
    .rd_req     (rd_req),
    .rx_event   (rx_event),
    .rd_ack     (rd_ack),
    .host_busy  (host_busy),
    .status     (status)
  );

endmodule

//--- sim/tb_uart_rx.sv
// Drives serial_in on falling edges at 8 samples per bit; the first failed check ends the run
`timescale 1ns/1ps

module tb_uart_rx;

  localparam int unsigned CLK_PERIOD_NS = 100;
  localparam int unsigned NUM_FRAMES    = 25;  // 24 full frames and one start glitch
  localparam int unsigned FRAME_BITS    = 10;  // Start, eight data, stop
  localparam int unsigned TIMEOUT_NS    =
    NUM_FRAMES * FRAME_BITS * uart_pkg::SAMPLES_PER_BIT * CLK_PERIOD_NS * 3 / 2;

  logic                   Sample_clk;
  logic                   reset_;
  logic                   serial_in;
  logic                   rd_req;
  logic                   rd_ack;
  uart_pkg::rx_word_t     rd_data;
  uart_pkg::host_status_t status;

  uart_pkg::rx_word_t     exp_data;    // Last good byte accepted
  uart_pkg::host_status_t exp_status;
  logic                   hold_check;  // Status and rd_data are settled

  uart_rx_top uart_rx_top_i (
    .Sample_clk (Sample_clk),
    .reset_     (reset_),
    .serial_in  (serial_in),
    .rd_req     (rd_req),
    .rd_ack     (rd_ack),
    .rd_data    (rd_data),
    .status     (status)
  );

  initial begin
    Sample_clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) Sample_clk = ~Sample_clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("error at %0d ns: %s expected 'h%0h, got 'h%0h", $time, name, expected, actual);
    $display("** FAIL **");
    $fatal(1, "wrong value on %s", name);
  endtask

  task automatic report_failure(input string what);
    $display("error at %0d ns: %s", $time, what);
    $display("** FAIL **");
    $fatal(1, "%s", what);
  endtask

  task automatic settle(input int cycles);
    repeat (cycles) @(negedge Sample_clk);
  endtask

  task automatic drive_level(input logic level, input int cycles);
    serial_in = level;
    repeat (cycles) @(negedge Sample_clk);
  endtask

  // Waits for the receiver's end-of-frame pulse and the edge that acts on it
  task automatic wait_frame_end();
    while (!uart_rx_top_i.rx_event.done) @(negedge Sample_clk);
    @(negedge Sample_clk);
  endtask

  // Full frame when start_cycles is a whole bit, otherwise only a start glitch
  task automatic send_frame(input uart_pkg::rx_word_t value, input int start_cycles,
                            input logic stop_low);
    uart_pkg::rx_word_t bits;
    int                 i;
    bits = value;
    if (start_cycles < uart_pkg::SAMPLES_PER_BIT) begin
      drive_level(1'b0, start_cycles);
      drive_level(1'b1, 4);
    end else begin
      drive_level(1'b0, start_cycles);
      for (i = 0; i < uart_pkg::WORD_SIZE; i++) begin
        drive_level(bits[0], uart_pkg::SAMPLES_PER_BIT);  // LSB first
        bits = bits >> 1;
      end
      serial_in = !stop_low;
      wait_frame_end();
      drive_level(1'b1, uart_pkg::SAMPLES_PER_BIT);  // Rest of stop bit and idle line
    end
  endtask

  task automatic expect_settled(input logic avail, input logic overrun, input logic framing);
    exp_status.data_avail   = avail;
    exp_status.overrun_seen = overrun;
    exp_status.framing_seen = framing;
    hold_check              = 1'b1;
    settle(3);
  endtask

  // Four-phase read that ends once rd_ack has dropped
  task automatic read_word();
    rd_req = 1'b1;
    @(negedge Sample_clk);
    while (!rd_ack) @(negedge Sample_clk);
    @(negedge Sample_clk);  // Host keeps the word one more cycle
    rd_req = 1'b0;
    @(negedge Sample_clk);
    while (rd_ack) @(negedge Sample_clk);
  endtask

  a_status_settled : assert property (
    @(posedge Sample_clk) disable iff (!reset_)
      hold_check |-> (status == exp_status)
  ) else report_mismatch("status", 32'(exp_status), 32'(status));

  a_data_held : assert property (
    @(posedge Sample_clk) disable iff (!reset_)
      (hold_check || rd_ack) |-> (rd_data == exp_data)
  ) else report_mismatch("rd_data", 32'(exp_data), 32'(rd_data));

  // Also covers rd_ack low after reset until the first rd_req
  a_ack_quiet : assert property (
    @(posedge Sample_clk) disable iff (!reset_)
      (!rd_req && !$past(rd_req)) |-> !rd_ack
  ) else report_mismatch("rd_ack", 32'(1'b0), 32'(rd_ack));

  a_ack_rise : assert property (
    @(posedge Sample_clk) disable iff (!reset_)
      (rd_ack && !$past(rd_ack)) |-> $past(rd_req)
  ) else report_failure("rd_ack rose while rd_req was low");

  a_ack_fall : assert property (
    @(posedge Sample_clk) disable iff (!reset_)
      (!rd_ack && $past(rd_ack)) |-> !$past(rd_req)
  ) else report_failure("rd_ack fell while rd_req was high");

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial begin
    uart_pkg::rx_word_t value;
    int                 n;
    serial_in  = 1'b1;
    rd_req     = 1'b0;
    reset_     = 1'b0;
    hold_check = 1'b0;
    exp_data   = '0;
    exp_status = '0;
    void'($urandom(26));
    repeat (4) @(negedge Sample_clk);
    reset_ = 1'b1;

    expect_settled(1'b0, 1'b0, 1'b0);  // All clear out of reset
    settle(4);

    for (n = 0; n < 20; n++) begin
      value      = uart_pkg::rx_word_t'($urandom());
      hold_check = 1'b0;
      send_frame(value, uart_pkg::SAMPLES_PER_BIT, 1'b0);
      exp_data = value;
      expect_settled(1'b1, 1'b0, 1'b0);
      read_word();
      expect_settled(1'b0, 1'b0, 1'b0);
    end

    // Checks stay armed for a whole frame time after the glitch
    send_frame(8'h00, uart_pkg::HALF_WORD - 2, 1'b0);
    settle(FRAME_BITS * uart_pkg::SAMPLES_PER_BIT);

    hold_check = 1'b0;
    send_frame(uart_pkg::rx_word_t'($urandom()), uart_pkg::SAMPLES_PER_BIT, 1'b1);
    expect_settled(1'b0, 1'b0, 1'b1);  // Old byte kept
    value      = uart_pkg::rx_word_t'($urandom());
    hold_check = 1'b0;
    send_frame(value, uart_pkg::SAMPLES_PER_BIT, 1'b0);
    exp_data = value;
    expect_settled(1'b1, 1'b0, 1'b1);
    read_word();
    expect_settled(1'b0, 1'b0, 1'b0);

    value      = uart_pkg::rx_word_t'($urandom());
    hold_check = 1'b0;
    send_frame(value, uart_pkg::SAMPLES_PER_BIT, 1'b0);
    exp_data = value;
    expect_settled(1'b1, 1'b0, 1'b0);
    hold_check = 1'b0;
    send_frame(uart_pkg::rx_word_t'($urandom()), uart_pkg::SAMPLES_PER_BIT, 1'b0);
    expect_settled(1'b1, 1'b1, 1'b0);  // Second byte dropped
    read_word();
    expect_settled(1'b0, 1'b0, 1'b0);

    $display("** PASS **");
    $finish;
  end

endmodule

//--- tb.f
common/uart_pkg.sv
rcvr/rcvr_controller.sv
rcvr/rcvr_datapath.sv
rcvr/uart_rcvr.sv
hdl/rx_host_port.sv
hdl/uart_rx_top.sv
sim/tb_uart_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the UART receive testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=tb_uart_rx
OBJ_DIR=obj_dir

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  -f tb.f \
  --top-module "${TOP}" \
  --Mdir "${OBJ_DIR}" \
  -o "V${TOP}"

"./${OBJ_DIR}/V${TOP}"
